/* Bender.yml */
package:
  name: emesh_node

sources:
  # Package first, then leaf blocks, then the top level
  - files:
      - verilog/emesh_pkg.sv
      - verilog/emesh_stim_fifo.sv
      - verilog/emesh_ememory.sv
      - verilog/emesh_arbiter.sv
      - verilog/emesh_monitor.sv
      - verilog/emesh_node.sv
  - target: test
    files:
      - tests/emesh_node_asserts.sv
      - tests/emesh_node_tb.sv

/* emesh_node.f */
verilog/emesh_pkg.sv
verilog/emesh_stim_fifo.sv
verilog/emesh_ememory.sv
verilog/emesh_arbiter.sv
verilog/emesh_monitor.sv
verilog/emesh_node.sv
tests/emesh_node_asserts.sv
tests/emesh_node_tb.sv

/* tests/emesh_node_asserts.sv */
// Link rules only hold after reset and the outgoing side is the node itself as sender
`timescale 1ns/10ps

module emesh_node_asserts import emesh_pkg::*; (
   input logic          clk,
   input logic          arst_n,
   input logic          in_wait,
   input logic          out_access,
   input logic          out_wait,
   input emesh_packet_t out_packet,
   input logic          overflow
);

   int fail_cnt = 0;   // Failed assertions so far

   // Sender keeps access and packet while the far side stalls
   out_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (out_access && out_wait) |=> (out_access && $stable(out_packet)))
      else begin
         fail_cnt++;
         $error("out_packet or out_access changed while out_wait was high");
      end

   // Nothing leaves and nothing stalls in reset
   rst_quiet: assert property (@(posedge clk) !arst_n |-> (!in_wait && !out_access))
      else begin
         fail_cnt++;
         $error("in_wait or out_access high during reset");
      end

   // Sticky flag
   ovf_sticky: assert property (@(posedge clk) disable iff (!arst_n) !$fell(overflow))
      else begin
         fail_cnt++;
         $error("overflow fell without a reset");
      end

endmodule

bind emesh_node emesh_node_asserts asserts0 (
   .clk        (clk),
   .arst_n     (arst_n),
   .in_wait    (in_wait),
   .out_access (out_access),
   .out_wait   (out_wait),
   .out_packet (out_packet),
   .overflow   (overflow)
);

/* tests/emesh_node_tb.sv */
// Single clock, reads only target words written before so every response value is known
`timescale 1ns/10ps

module emesh_node_tb import emesh_pkg::*; ();

   localparam logic [IDW-1:0] COREID = 12'h5A3;
   localparam int RST_CYCLES = 16;
   localparam int N_SEQ      = 24;  // Writes, then as many reads
   localparam int N_HOST     = 16;
   localparam int N_BP       = 20;  // Per back-pressure run
   localparam int NUM_OPS    = 2*N_SEQ + N_HOST + 4 + 2*N_BP + 2 + 5;

   logic             clk;
   logic             arst_n;
   logic [IDW-1:0]   coreid;
   logic             host_valid;
   emesh_packet_t    host_packet;
   logic             in_access;
   emesh_packet_t    in_packet;
   logic             in_wait;
   logic             out_access;
   emesh_packet_t    out_packet;
   logic             out_wait;
   logic             overflow;
   logic             misroute;
   logic [CNT_W-1:0] cnt_wr_in;
   logic [CNT_W-1:0] cnt_rd_in;
   logic [CNT_W-1:0] cnt_out;

   //####################################################################
   // Reference model state
   //####################################################################

   logic [31:0]       lfsr_state = 32'd71128;
   logic [AW-1:0]     mem_model [2**MEM_AW];
   logic [MEM_AW-1:0] written [$];        // Word indices safe to read
   emesh_packet_t     exp_q [$];          // Outgoing order
   bit                exp_is_resp [$];
   emesh_packet_t     held_resp;          // Last response built
   int                resp_pending = 0;   // Responses not yet out
   logic [CNT_W-1:0]  exp_wr = '0;
   logic [CNT_W-1:0]  exp_rd = '0;
   logic [CNT_W-1:0]  exp_out = '0;       // Packets the model sends out
   bit                wait_rand = 1'b0;   // Random out_wait per cycle

   emesh_node dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //####################################################################
   // Helpers
   //####################################################################

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_packet(input string name, input emesh_packet_t exp_p,
                               input emesh_packet_t act);
      if (act !== exp_p) begin
         fail_now($sformatf("mismatch %s expected %h got %h", name, exp_p, act));
      end
   endtask

   task automatic check_count(input string name, input logic [CNT_W-1:0] exp_c,
                              input logic [CNT_W-1:0] act);
      if (act !== exp_c) begin
         fail_now($sformatf("mismatch %s expected %h got %h", name, exp_c, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp_f, input logic act);
      if (act !== exp_f) begin
         fail_now($sformatf("mismatch %s expected %h got %h", name, exp_f, act));
      end
   endtask

   // Galois form, one step per bit
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      repeat (n) v = {v[30:0], lfsr_bit()};
      return v;
   endfunction

   function automatic emesh_packet_t random_packet();
      emesh_packet_t p;
      p.srcaddr  = take_bits(AW);
      p.data     = take_bits(AW);
      p.dstaddr  = take_bits(AW);
      p.ctrlmode = 5'(take_bits(5));
      p.datamode = 2'(take_bits(2));
      p.write    = 1'(take_bits(1));
      return p;
   endfunction

   // Word access to idx on core id, bits 19..10 stay random
   function automatic emesh_packet_t mem_packet(input logic wr, input logic [MEM_AW-1:0] idx,
                                                input logic [IDW-1:0] id);
      emesh_packet_t p;
      p          = random_packet();
      p.dstaddr  = {id, p.dstaddr[19:10], idx, 2'b00};
      p.datamode = 2'd2;
      p.write    = wr;
      return p;
   endfunction

   function automatic logic [MEM_AW-1:0] pick_idx();
      return written[take_bits(8) % written.size()];
   endfunction

   // One cycle, inputs change 1 ns after the edge
   task automatic tick();
      @(posedge clk);
      #1;
      host_valid = 1'b0;
      if (wait_rand) out_wait = lfsr_bit();
   endtask

   task automatic push_expect(input emesh_packet_t p, input bit is_resp);
      exp_q.push_back(p);
      exp_is_resp.push_back(is_resp);
      exp_out++;
   endtask

   task automatic inject_host(input emesh_packet_t p);
      host_valid  = 1'b1;
      host_packet = p;
      push_expect(p, 1'b0);
      tick();
   endtask

   // Holds the packet on the link until the node takes it
   task automatic send_in(input emesh_packet_t p, input bit defer);
      emesh_packet_t     r;
      logic [MEM_AW-1:0] idx;
      int                n;
      idx       = p.dstaddr[MEM_AW+1:2];
      n         = 0;
      in_access = 1'b1;
      in_packet = p;
      @(negedge clk);
      while (in_wait) begin
         n++;
         if (n > 400) begin
            fail_now("incoming packet was never accepted");
         end else begin
            tick();
            @(negedge clk);
         end
      end
      tick();                                 // Transfer edge
      in_access = 1'b0;
      if (p.write) begin
         mem_model[idx] = p.data;
         exp_wr++;
      end else begin
         r.write    = 1'b1;                   // Reply is a word write
         r.datamode = 2'd2;
         r.ctrlmode = 5'd0;
         r.dstaddr  = p.srcaddr;              // Back to requester
         r.data     = mem_model[idx];
         r.srcaddr  = {COREID, {(AW-IDW){1'b0}}};
         exp_rd++;
         resp_pending++;
         held_resp = r;
         if (!defer) push_expect(r, 1'b1);
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 400) begin
         tick();
         n++;
      end
      if (exp_q.size() != 0) begin
         fail_now("outgoing packets missing, queue did not drain");
      end else begin
         repeat (3) tick();                   // Counters settle
      end
   endtask

   //####################################################################
   // Outgoing link monitor, sampled mid cycle
   //####################################################################

   always @(negedge clk) begin
      if (arst_n) begin
         if (dut0.asserts0.fail_cnt != 0) begin
            fail_now("a link assertion failed");
         end
         check_flag("in_wait", resp_pending != 0, in_wait);  // Blocked response stalls input
         if (out_access && !out_wait) begin
            if (exp_q.size() == 0) begin
               fail_now("unexpected packet on the outgoing link");
            end else begin
               check_packet("out_packet", exp_q[0], out_packet);
               if (exp_is_resp[0]) resp_pending--;
               void'(exp_q.pop_front());
               void'(exp_is_resp.pop_front());
            end
         end
      end
   end

   initial begin
      repeat (RST_CYCLES + 40*NUM_OPS) @(posedge clk);
      fail_now("watchdog timeout, the run did not finish");
   end

   //####################################################################
   // Test sequence
   //####################################################################

   initial begin
      emesh_packet_t     p;
      emesh_packet_t     h1;
      logic [MEM_AW-1:0] idx;
      int                i;
      arst_n      = 1'b0;
      coreid      = COREID;
      host_valid  = 1'b0;
      host_packet = '0;
      in_access   = 1'b0;
      in_packet   = '0;
      out_wait    = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;
      tick();

      // Writes then reads of the same words
      for (i = 0; i < N_SEQ; i++) begin
         idx = MEM_AW'(take_bits(MEM_AW));
         written.push_back(idx);
         send_in(mem_packet(1'b1, idx, COREID), 1'b0);
         repeat (take_bits(2)) tick();
      end
      for (i = 0; i < N_SEQ; i++) begin
         send_in(mem_packet(1'b0, pick_idx(), COREID), 1'b0);
      end
      drain();

      // Host passthrough with free link
      for (i = 0; i < N_HOST; i++) begin
         inject_host(random_packet());
         repeat (take_bits(2)) tick();
      end
      drain();

      // Host head waits, then a read response joins behind it
      out_wait = 1'b1;
      h1 = random_packet();
      inject_host(h1);
      send_in(mem_packet(1'b0, pick_idx(), COREID), 1'b1);
      inject_host(random_packet());
      inject_host(random_packet());
      push_expect(held_resp, 1'b1);           // After every host packet
      check_flag("out_access", 1'b1, out_access);
      check_packet("out_packet", h1, out_packet);
      out_wait = 1'b0;
      drain();

      // Back-pressure, host only then memory only
      wait_rand = 1'b1;
      for (i = 0; i < N_BP; i++) begin
         while (exp_q.size() >= FIFO_DEPTH) begin
            tick();
         end
         inject_host(random_packet());
      end
      drain();
      for (i = 0; i < N_BP; i++) begin
         if (take_bits(1)) begin
            idx = MEM_AW'(take_bits(MEM_AW));
            written.push_back(idx);
            send_in(mem_packet(1'b1, idx, COREID), 1'b0);
         end else begin
            send_in(mem_packet(1'b0, pick_idx(), COREID), 1'b0);
         end
      end
      drain();
      wait_rand = 1'b0;
      out_wait  = 1'b0;

      // Foreign core id, flag only after acceptance
      check_flag("misroute", 1'b0, misroute);
      out_wait = 1'b1;                        // Response stays, in_wait stays up
      send_in(mem_packet(1'b0, pick_idx(), COREID), 1'b0);
      p = mem_packet(1'b1, MEM_AW'(take_bits(MEM_AW)), ~COREID);
      in_access = 1'b1;
      in_packet = p;
      repeat (3) tick();
      check_flag("misroute", 1'b0, misroute);
      out_wait = 1'b0;
      send_in(p, 1'b0);
      check_flag("misroute", 1'b1, misroute);
      drain();

      // Overflow, fifth strobe into a full queue
      out_wait = 1'b1;
      check_flag("overflow", 1'b0, overflow);
      for (i = 0; i < 5; i++) begin
         p           = random_packet();
         host_valid  = 1'b1;
         host_packet = p;
         if (i < FIFO_DEPTH) push_expect(p, 1'b0);
         tick();
      end
      check_flag("overflow", 1'b1, overflow);
      out_wait = 1'b0;
      drain();
      repeat (10) tick();                     // Dropped one must not appear

      check_count("cnt_wr_in", exp_wr, cnt_wr_in);
      check_count("cnt_rd_in", exp_rd, cnt_rd_in);
      check_count("cnt_out", exp_out, cnt_out);

      if (dut0.asserts0.fail_cnt == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         fail_now("a link assertion failed near the end of the run");
      end
   end

endmodule

/* verilog/emesh_arbiter.sv */
// Stimulus wins unless a response is already stalled on the link and must stay put until taken
`timescale 1ns/10ps

module emesh_arbiter import emesh_pkg::*; (
   input  logic          clk,
   input  logic          arst_n,
   // Stimulus queue head
   input  logic          stim_valid,
   input  emesh_packet_t stim_packet,
   // Memory response
   input  logic          resp_valid,
   input  emesh_packet_t resp_packet,
   // Outgoing link
   input  logic          out_wait,
   output logic          stim_pop,
   output logic          resp_pop,
   output logic          out_access,
   output emesh_packet_t out_packet
);

   //####################################################################
   // Selection
   //####################################################################

   logic sel_resp;     // Response drives the link this cycle
   logic resp_locked;  // Response was presented under wait last cycle

   // A host packet that shows up while a response waits must not
   // replace it on the link, eMesh senders hold until accepted
   assign sel_resp = resp_locked | (~stim_valid & resp_valid);

   assign out_access = stim_valid | resp_valid;               // Zero cycle path
   assign out_packet = sel_resp ? resp_packet : stim_packet;

   // One pop per transfer edge, loser keeps its valid
   assign stim_pop = out_access & ~out_wait & ~sel_resp;
   assign resp_pop = out_access & ~out_wait & sel_resp;

   //####################################################################
   // Hold under wait
   //####################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         resp_locked <= 1'b0;
      end else begin
         resp_locked <= sel_resp & out_wait; // Cleared by the transfer edge
      end
   end

   // Stimulus under wait needs no lock since the head only moves on a pop

endmodule

/* verilog/emesh_ememory.sv */
// Holds one read response at a time and stalls the incoming link through in_wait until it leaves
`timescale 1ns/10ps

module emesh_ememory import emesh_pkg::*; (
   input  logic           clk,
   input  logic           arst_n,
   input  logic [IDW-1:0] coreid,        // Used for the response source
   // Incoming link
   input  logic           in_access,
   input  emesh_packet_t  in_packet,
   output logic           in_wait,       // High while a response is pending
   // Response to the arbiter
   input  logic           resp_pop,
   output logic           resp_valid,
   output emesh_packet_t  resp_packet
);

   //####################################################################
   // Incoming transfer decode
   //####################################################################

   logic [AW-1:0]     mem [2**MEM_AW];  // Word array, no reset
   logic [MEM_AW-1:0] word_idx;
   logic              in_xfer;
   logic              wr_accept;
   logic              rd_accept;

   assign in_wait   = resp_valid;             // Single response slot
   assign in_xfer   = in_access & ~in_wait;   // Link transfer edge
   assign wr_accept = in_xfer & in_packet.write;
   assign rd_accept = in_xfer & ~in_packet.write;

   // Byte address to word index, core id bits ignored here
   assign word_idx = in_packet.dstaddr[MEM_AW+1:2];

   //####################################################################
   // Word storage
   //####################################################################

   always_ff @(posedge clk) begin
      if (wr_accept) begin
         mem[word_idx] <= in_packet.data;   // Full 32-bit word
      end
   end

   //####################################################################
   // Read response
   //####################################################################

   // Response payload is loaded only on a read, no reset
   always_ff @(posedge clk) begin
      if (rd_accept) begin
         resp_packet.write    <= 1'b1;                       // Reply is a write
         resp_packet.datamode <= 2'd2;                       // 32-bit word
         resp_packet.ctrlmode <= 5'd0;
         resp_packet.dstaddr  <= in_packet.srcaddr;          // Back to requester
         resp_packet.data     <= mem[word_idx];              // Earlier writes visible
         resp_packet.srcaddr  <= {coreid, {(AW-IDW){1'b0}}}; // This node, offset 0
      end
   end

   // Valid from the cycle after the read until the arbiter takes it
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         resp_valid <= 1'b0;
      end else if (rd_accept) begin
         resp_valid <= 1'b1;
      end else if (resp_pop) begin
         resp_valid <= 1'b0;
      end
   end

   // A read cannot be accepted on a pop edge since in_wait is still high
   // so the two branches above never compete

endmodule

/* verilog/emesh_monitor.sv */
// Counters wrap at CNT_W bits and misroute stays set until reset
`timescale 1ns/10ps

module emesh_monitor import emesh_pkg::*; (
   input  logic             clk,
   input  logic             arst_n,
   input  logic [IDW-1:0]   coreid,      // This node
   // Incoming link, observed
   input  logic             in_access,
   input  logic             in_wait,
   input  emesh_packet_t    in_packet,
   // Outgoing link, observed
   input  logic             out_access,
   input  logic             out_wait,
   // Status
   output logic             misroute,    // Foreign core id accepted
   output logic [CNT_W-1:0] cnt_wr_in,   // Accepted incoming writes
   output logic [CNT_W-1:0] cnt_rd_in,   // Accepted incoming reads
   output logic [CNT_W-1:0] cnt_out      // Completed outgoing transfers
);

   //####################################################################
   // Transfer detect
   //####################################################################

   logic in_xfer;
   logic out_xfer;
   logic id_miss;

   assign in_xfer  = in_access & ~in_wait;
   assign out_xfer = out_access & ~out_wait;

   // Destination core id against ours
   assign id_miss = (in_packet.dstaddr[AW-1:AW-IDW] != coreid);

   //####################################################################
   // Counters and flag
   //####################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_wr_in <= '0;
         cnt_rd_in <= '0;
         cnt_out   <= '0;
         misroute  <= 1'b0;
      end else begin
         if (in_xfer & in_packet.write) begin
            cnt_wr_in <= cnt_wr_in + 1'b1;   // Wraps
         end
         if (in_xfer & ~in_packet.write) begin
            cnt_rd_in <= cnt_rd_in + 1'b1;
         end
         if (out_xfer) begin
            cnt_out <= cnt_out + 1'b1;       // Host packets and responses
         end
         if (in_xfer & id_miss) begin
            misroute <= 1'b1;                // Sticky
         end
      end
   end

   // A packet held under in_wait is not counted until it goes through

endmodule

/* verilog/emesh_node.sv */
// Single clock endpoint with one channel where the node drives in_wait and the far side drives out_wait
`timescale 1ns/10ps

module emesh_node import emesh_pkg::*; (
   input  logic             clk,
   input  logic             arst_n,
   input  logic [IDW-1:0]   coreid,
   // Host inject
   input  logic             host_valid,
   input  emesh_packet_t    host_packet,
   // Incoming link
   input  logic             in_access,
   input  emesh_packet_t    in_packet,
   output logic             in_wait,
   // Outgoing link
   output logic             out_access,
   output emesh_packet_t    out_packet,
   input  logic             out_wait,
   // Status
   output logic             overflow,
   output logic             misroute,
   output logic [CNT_W-1:0] cnt_wr_in,
   output logic [CNT_W-1:0] cnt_rd_in,
   output logic [CNT_W-1:0] cnt_out
);

   //####################################################################
   // Internal links
   //####################################################################

   logic          stim_valid;   // Queue head present
   logic          stim_pop;
   emesh_packet_t stim_packet;
   logic          resp_valid;   // Read response pending
   logic          resp_pop;
   emesh_packet_t resp_packet;

   //####################################################################
   // Blocks
   //####################################################################

   // Host packet queue
   emesh_stim_fifo stim_fifo0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .host_valid  (host_valid),
      .host_packet (host_packet),
      .stim_pop    (stim_pop),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .overflow    (overflow)
   );

   // Answers incoming link traffic
   emesh_ememory ememory0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .coreid      (coreid),
      .in_access   (in_access),
      .in_packet   (in_packet),
      .in_wait     (in_wait),
      .resp_pop    (resp_pop),
      .resp_valid  (resp_valid),
      .resp_packet (resp_packet)
   );

   // Stimulus first onto the outgoing link
   emesh_arbiter arbiter0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .resp_valid  (resp_valid),
      .resp_packet (resp_packet),
      .out_wait    (out_wait),
      .stim_pop    (stim_pop),
      .resp_pop    (resp_pop),
      .out_access  (out_access),
      .out_packet  (out_packet)
   );

   // Watches both links
   emesh_monitor monitor0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .coreid     (coreid),
      .in_access  (in_access),
      .in_wait    (in_wait),
      .in_packet  (in_packet),
      .out_access (out_access),
      .out_wait   (out_wait),
      .misroute   (misroute),
      .cnt_wr_in  (cnt_wr_in),
      .cnt_rd_in  (cnt_rd_in),
      .cnt_out    (cnt_out)
   );

endmodule

/* verilog/emesh_pkg.sv */
// Shared eMesh widths and packet layout for a single channel node with 32-bit word traffic only
package emesh_pkg;

   //####################################################################
   // Widths
   //####################################################################

   localparam int AW  = 32;        // Address and data width
   localparam int PW  = 2*AW+40;   // Packet width, 104 bits
   localparam int IDW = 12;        // Core id width, top bits of dstaddr

   //####################################################################
   // Local resources
   //####################################################################

   localparam int MEM_AW     = 8;  // 256 words in the endpoint memory
   localparam int FIFO_DEPTH = 4;  // Host packet queue entries
   localparam int CNT_W      = 16; // Traffic counters, wrap on overflow

   //####################################################################
   // Packet
   //####################################################################

   // Same bit order as the flat eMesh packet
   // srcaddr sits on top and write is bit 0
   typedef struct packed {
      logic [AW-1:0] srcaddr;      // Return address for reads
      logic [AW-1:0] data;         // Write data or read payload
      logic [AW-1:0] dstaddr;      // Core id in 31..20 then local address
      logic [4:0]    ctrlmode;     // Carried along and not interpreted
      logic [1:0]    datamode;     // 2 means 32-bit word
      logic          write;        // 1 write, 0 read request
   } emesh_packet_t;

endpackage

/* verilog/emesh_stim_fifo.sv */
// Host queue has no back-pressure and a strobe into a full queue is dropped with sticky overflow
`timescale 1ns/10ps

module emesh_stim_fifo import emesh_pkg::*; (
   input  logic          clk,
   input  logic          arst_n,
   // Host side
   input  logic          host_valid,    // One cycle strobe
   input  emesh_packet_t host_packet,   // Sampled with the strobe
   // Arbiter side
   input  logic          stim_pop,      // Head leaves on this edge
   output logic          stim_valid,    // Queue not empty
   output emesh_packet_t stim_packet,   // Head of queue
   // Status
   output logic          overflow       // Sticky until reset
);

   //####################################################################
   // Storage and pointers
   //####################################################################

   emesh_packet_t                      buf_mem [FIFO_DEPTH]; // Payload only, no reset
   logic [$clog2(FIFO_DEPTH)-1:0]      wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0]      rd_ptr;
   logic [$clog2(FIFO_DEPTH+1)-1:0]    count;
   logic                               full;
   logic                               push;
   logic                               pop;

   assign full  = (count == FIFO_DEPTH);
   assign pop   = stim_pop & stim_valid;          // Guard against a stray pop
   assign push  = host_valid & (~full | pop);     // Full slot frees up on a pop

   assign stim_valid  = (count != 0);
   assign stim_packet = buf_mem[rd_ptr];          // Head visible one cycle after push

   // Payload write, no reset needed
   always_ff @(posedge clk) begin
      if (push) begin
         buf_mem[wr_ptr] <= host_packet;
      end
   end

   //####################################################################
   // Control
   //####################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (push) begin
            // Wrap at depth so odd depths also work
            wr_ptr <= (wr_ptr == FIFO_DEPTH-1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == FIFO_DEPTH-1) ? '0 : rd_ptr + 1'b1;
         end
         // Net occupancy change
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // Both or neither
         endcase
         if (host_valid & ~push) begin
            overflow <= 1'b1;             // Packet lost, flag stays up
         end
      end
   end

endmodule
